// ==== source/matrix_pkg.sv ====
package matrix_pkg;

    // one byte as it comes off the serial line
    typedef logic [7:0] data_byte_t;

    // display-control state driven to the LED scanner
    // rgb_enable: bit 0 red, bit 1 green, bit 2 blue
    // brightness_enable: bit 5 is plane 1 down to bit 0 for plane 6
    typedef struct packed {
        logic [2:0] rgb_enable;
        logic [5:0] brightness_enable;
    } display_ctrl_t;

    // everything on after reset
    localparam display_ctrl_t display_ctrl_reset = '{
        rgb_enable:        3'b111,
        brightness_enable: 6'b111111
    };

    // colour commands, upper case sets and lower case clears
    localparam data_byte_t cmd_red_on    = "R";
    localparam data_byte_t cmd_red_off   = "r";
    localparam data_byte_t cmd_green_on  = "G";
    localparam data_byte_t cmd_green_off = "g";
    localparam data_byte_t cmd_blue_on   = "B";
    localparam data_byte_t cmd_blue_off  = "b";

    // brightness plane toggles
    localparam data_byte_t cmd_plane_1 = "1";
    localparam data_byte_t cmd_plane_2 = "2";
    localparam data_byte_t cmd_plane_3 = "3";
    localparam data_byte_t cmd_plane_4 = "4";
    localparam data_byte_t cmd_plane_5 = "5";
    localparam data_byte_t cmd_plane_6 = "6";
    localparam data_byte_t cmd_planes_off = "0";
    localparam data_byte_t cmd_planes_on  = "9";

    // line load: "L", row byte, then one full row of pixel bytes
    localparam data_byte_t cmd_line = "L";

endpackage

// ==== source/uart_rx.sv ====
module uart_rx
    import matrix_pkg::*;
#(
    parameter int clk_ticks_per_bit = 8
) (
    input  logic       clk_in,
    input  logic       reset,
    input  logic       serial_in,
    output data_byte_t rx_byte,
    output logic       rx_valid,
    output logic       rx_busy
);

    localparam int tick_bits = $clog2(clk_ticks_per_bit + 1);
    localparam logic [tick_bits-1:0] last_tick = tick_bits'(clk_ticks_per_bit - 1);
    localparam logic [tick_bits-1:0] half_tick = tick_bits'((clk_ticks_per_bit - 1) / 2);

    typedef enum logic [2:0] {
        rx_idle,
        rx_start,
        rx_data,
        rx_stop,
        rx_recover
    } rx_state_t;

    rx_state_t            state;
    logic [1:0]           serial_sync;
    logic                 serial_prev;
    logic [tick_bits-1:0] tick_count;
    logic [2:0]           bit_index;
    data_byte_t           shift_reg;

    // two-stage synchroniser, line idles high
    always_ff @(posedge clk_in) begin
        if (reset) begin
            serial_sync <= 2'b11;
            serial_prev <= 1'b1;
        end else begin
            serial_sync <= {serial_sync[0], serial_in};
            serial_prev <= serial_sync[1];
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state      <= rx_idle;
            tick_count <= '0;
            bit_index  <= 3'd0;
            rx_valid   <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                rx_idle: begin
                    tick_count <= '0;
                    bit_index  <= 3'd0;
                    // falling edge marks the start bit
                    if (serial_prev && !serial_sync[1]) begin
                        state <= rx_start;
                    end
                end
                rx_start: begin
                    if (tick_count == half_tick) begin
                        tick_count <= '0;
                        // glitch, not a real start bit
                        state <= serial_sync[1] ? rx_idle : rx_data;
                    end else begin
                        tick_count <= tick_count + 1'b1;
                    end
                end
                rx_data: begin
                    if (tick_count == last_tick) begin
                        tick_count <= '0;
                        bit_index  <= bit_index + 1'b1;
                        if (bit_index == 3'd7) begin
                            state <= rx_stop;
                        end
                    end else begin
                        tick_count <= tick_count + 1'b1;
                    end
                end
                rx_stop: begin
                    if (tick_count == last_tick) begin
                        tick_count <= '0;
                        if (serial_sync[1]) begin
                            rx_valid <= 1'b1;
                            state    <= rx_idle;
                        end else begin
                            // framing error, byte is dropped
                            state <= rx_recover;
                        end
                    end else begin
                        tick_count <= tick_count + 1'b1;
                    end
                end
                rx_recover: begin
                    if (serial_sync[1]) begin
                        state <= rx_idle;
                    end
                end
                default: begin
                    state <= rx_idle;
                end
            endcase
        end
    end

    // data bits arrive lsb first, sampled at mid-bit
    always_ff @(posedge clk_in) begin
        if (state == rx_data && tick_count == last_tick) begin
            shift_reg <= {serial_sync[1], shift_reg[7:1]};
        end
    end

    assign rx_byte = shift_reg;
    assign rx_busy = (state == rx_start) || (state == rx_data) || (state == rx_stop);

endmodule

// ==== source/command_decoder.sv ====
module command_decoder
    import matrix_pkg::*;
#(
    parameter int pixel_width     = 64,
    parameter int pixel_height    = 32,
    parameter int bytes_per_pixel = 2,
    localparam int row_bits   = $clog2(pixel_height),
    localparam int col_bits   = $clog2(pixel_width * bytes_per_pixel),
    localparam int addr_width = row_bits + col_bits
) (
    input  logic                  clk_in,
    input  logic                  reset,
    input  data_byte_t            rx_byte,
    input  logic                  rx_valid,
    output display_ctrl_t         display_ctrl,
    output logic                  wr_en,
    output logic [addr_width-1:0] wr_address,
    output data_byte_t            wr_data,
    output logic [7:0]            commands_done
);

    localparam logic [col_bits-1:0] col_max = col_bits'(pixel_width * bytes_per_pixel - 1);

    typedef enum logic [1:0] {
        dec_idle,
        dec_row_wait,
        dec_data_load
    } dec_state_t;

    dec_state_t          state;
    logic [row_bits-1:0] row;
    logic [col_bits-1:0] col;
    logic [addr_width-1:0] mapped_address;

    // upper column bits inverted so pixels go out in ascending order,
    // byte select in bit 0 kept as is
    assign mapped_address = {row, ~col[col_bits-1:1], col[0]};

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state         <= dec_idle;
            row           <= '0;
            col           <= '0;
            display_ctrl  <= display_ctrl_reset;
            wr_en         <= 1'b0;
            commands_done <= 8'd0;
        end else begin
            wr_en <= 1'b0;
            if (rx_valid) begin
                case (state)
                    dec_idle: begin
                        case (rx_byte)
                            cmd_red_on:     display_ctrl.rgb_enable[0] <= 1'b1;
                            cmd_red_off:    display_ctrl.rgb_enable[0] <= 1'b0;
                            cmd_green_on:   display_ctrl.rgb_enable[1] <= 1'b1;
                            cmd_green_off:  display_ctrl.rgb_enable[1] <= 1'b0;
                            cmd_blue_on:    display_ctrl.rgb_enable[2] <= 1'b1;
                            cmd_blue_off:   display_ctrl.rgb_enable[2] <= 1'b0;
                            cmd_plane_1: begin
                                display_ctrl.brightness_enable[5] <=
                                    ~display_ctrl.brightness_enable[5];
                            end
                            cmd_plane_2: begin
                                display_ctrl.brightness_enable[4] <=
                                    ~display_ctrl.brightness_enable[4];
                            end
                            cmd_plane_3: begin
                                display_ctrl.brightness_enable[3] <=
                                    ~display_ctrl.brightness_enable[3];
                            end
                            cmd_plane_4: begin
                                display_ctrl.brightness_enable[2] <=
                                    ~display_ctrl.brightness_enable[2];
                            end
                            cmd_plane_5: begin
                                display_ctrl.brightness_enable[1] <=
                                    ~display_ctrl.brightness_enable[1];
                            end
                            cmd_plane_6: begin
                                display_ctrl.brightness_enable[0] <=
                                    ~display_ctrl.brightness_enable[0];
                            end
                            cmd_planes_off: display_ctrl.brightness_enable <= 6'b000000;
                            cmd_planes_on:  display_ctrl.brightness_enable <= 6'b111111;
                            cmd_line:       state <= dec_row_wait;
                            // unknown bytes are dropped
                            default: ;
                        endcase
                    end
                    dec_row_wait: begin
                        // a repeated "L" keeps waiting for the row
                        if (rx_byte != cmd_line) begin
                            row   <= rx_byte[row_bits-1:0];
                            col   <= col_max;
                            state <= dec_data_load;
                        end
                    end
                    dec_data_load: begin
                        wr_en <= 1'b1;
                        if (col == '0) begin
                            commands_done <= commands_done + 8'd1;
                            state         <= dec_idle;
                        end else begin
                            col <= col - 1'b1;
                        end
                    end
                    default: begin
                        state <= dec_idle;
                    end
                endcase
            end
        end
    end

    // write address and pixel byte, qualified by wr_en
    always_ff @(posedge clk_in) begin
        if (rx_valid && state == dec_data_load) begin
            wr_address <= mapped_address;
            wr_data    <= rx_byte;
        end
    end

endmodule

// ==== source/frame_ram.sv ====
module frame_ram #(
    parameter int address_width = 12
) (
    input  logic                     clk_in,
    input  logic                     wr_en,
    input  logic [address_width-1:0] wr_address,
    input  logic [7:0]               wr_data,
    input  logic [address_width-1:0] read_address,
    output logic [7:0]               read_data
);

    localparam int depth = 1 << address_width;

    // one pixel byte per word, row index in the upper address bits
    logic [7:0] memory [depth];

    // write port, fed by the command decoder
    always_ff @(posedge clk_in) begin
        if (wr_en) begin
            memory[wr_address] <= wr_data;
        end
    end

    // scanner side read port, one cycle of latency
    always_ff @(posedge clk_in) begin
        read_data <= memory[read_address];
    end

endmodule

// ==== source/matrix_control_top.sv ====
module matrix_control_top
    import matrix_pkg::*;
#(
    parameter int clk_ticks_per_bit = 8,
    parameter int pixel_width       = 64,
    parameter int pixel_height      = 32,
    parameter int bytes_per_pixel   = 2,
    // row bits plus column bits, 5 + 7 for a 64x32 panel at 2 bytes per pixel
    localparam int address_width = $clog2(pixel_height)
                                 + $clog2(pixel_width * bytes_per_pixel)
) (
    input  logic                     clk_in,
    input  logic                     reset,
    input  logic                     serial_in,
    output logic                     rx_busy,
    output display_ctrl_t            display_ctrl,
    output logic [7:0]               commands_done,
    input  logic [address_width-1:0] read_address,
    output logic [7:0]               read_data
);

    data_byte_t               rx_byte;
    logic                     rx_valid;
    logic                     wr_en;
    logic [address_width-1:0] wr_address;
    data_byte_t               wr_data;

    uart_rx #(
        .clk_ticks_per_bit(clk_ticks_per_bit)
    ) uart_rx_i (
        .clk_in   (clk_in),
        .reset    (reset),
        .serial_in(serial_in),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid),
        .rx_busy  (rx_busy)
    );

    command_decoder #(
        .pixel_width    (pixel_width),
        .pixel_height   (pixel_height),
        .bytes_per_pixel(bytes_per_pixel)
    ) command_decoder_i (
        .clk_in       (clk_in),
        .reset        (reset),
        .rx_byte      (rx_byte),
        .rx_valid     (rx_valid),
        .display_ctrl (display_ctrl),
        .wr_en        (wr_en),
        .wr_address   (wr_address),
        .wr_data      (wr_data),
        .commands_done(commands_done)
    );

    // frame memory holds the whole panel
    frame_ram #(
        .address_width(address_width)
    ) frame_ram_i (
        .clk_in      (clk_in),
        .wr_en       (wr_en),
        .wr_address  (wr_address),
        .wr_data     (wr_data),
        .read_address(read_address),
        .read_data   (read_data)
    );

endmodule

// ==== sim/tb_checker.sv ====
module tb_checker
    import matrix_pkg::*;
#(
    parameter int pixel_width     = 64,
    parameter int pixel_height    = 32,
    parameter int bytes_per_pixel = 2,
    localparam int row_bits   = $clog2(pixel_height),
    localparam int addr_width = row_bits + $clog2(pixel_width * bytes_per_pixel)
) (
    input  logic                  clk_in,
    input  logic                  byte_strobe,
    input  data_byte_t            byte_value,
    input  logic [191:0]          test_name,
    input  logic                  test_end,
    output logic                  test_done,
    input  logic                  rx_busy,
    input  display_ctrl_t         display_ctrl,
    input  logic [7:0]            commands_done,
    output logic [addr_width-1:0] read_address,
    input  logic [7:0]            read_data,
    output int                    tests_run,
    output int                    tests_failed,
    output int                    error_count
);

    localparam int row_bytes = pixel_width * bytes_per_pixel;
    localparam int col_bits  = addr_width - row_bits;

    display_ctrl_t           model_display;
    logic [7:0]              model_done;
    logic [7:0]              model_frame [1 << addr_width];
    logic [pixel_height-1:0] rows_touched;
    int                      model_phase;
    int                      model_row;
    int                      model_k;
    int                      test_errors;

    // display state after one byte received while idle
    function automatic display_ctrl_t expected_display(display_ctrl_t cur, data_byte_t b);
        display_ctrl_t nxt;
        int            plane;
        nxt   = cur;
        plane = int'(b) - int'(cmd_planes_off);
        case (b)
            cmd_red_on:     nxt.rgb_enable[0] = 1'b1;
            cmd_red_off:    nxt.rgb_enable[0] = 1'b0;
            cmd_green_on:   nxt.rgb_enable[1] = 1'b1;
            cmd_green_off:  nxt.rgb_enable[1] = 1'b0;
            cmd_blue_on:    nxt.rgb_enable[2] = 1'b1;
            cmd_blue_off:   nxt.rgb_enable[2] = 1'b0;
            cmd_planes_off: nxt.brightness_enable = '0;
            cmd_planes_on:  nxt.brightness_enable = '1;
            default: begin
                // plane n sits in bit 6 - n
                if (plane >= 1 && plane <= 6) begin
                    nxt.brightness_enable = cur.brightness_enable ^ (6'b100000 >> (plane - 1));
                end
            end
        endcase
        return nxt;
    endfunction

    // data byte k of a row goes to column counter c = row_bytes - 1 - k
    function automatic int expected_address(int row, int k);
        int c;
        int upper;
        c     = row_bytes - 1 - k;
        upper = (~c >> 1) & (row_bytes / 2 - 1);
        return (row << col_bits) | (upper << 1) | (c & 1);
    endfunction

    task automatic apply_byte(input data_byte_t b);
        if (model_phase == 0) begin
            if (b == cmd_line) begin
                model_phase = 1;
            end else begin
                model_display = expected_display(model_display, b);
            end
        end else if (model_phase == 1) begin
            if (b != cmd_line) begin
                model_row   = int'(b) % pixel_height;
                model_k     = 0;
                model_phase = 2;
            end
        end else begin
            model_frame[addr_width'(expected_address(model_row, model_k))] = b;
            rows_touched[row_bits'(model_row)] = 1'b1;
            model_k++;
            if (model_k == row_bytes) begin
                model_done  = model_done + 8'd1;
                model_phase = 0;
            end
        end
    endtask

    task automatic compare_state();
        if (display_ctrl !== model_display) begin
            $display("FAILED %0s display_ctrl expected %03h actual %03h",
                     test_name, model_display, display_ctrl);
            test_errors++;
        end
        if (commands_done !== model_done) begin
            $display("FAILED %0s commands_done expected %0d actual %0d",
                     test_name, model_done, commands_done);
            test_errors++;
        end
        // receiver is idle between frames
        if (rx_busy !== 1'b0) begin
            $display("FAILED %0s rx_busy expected 0 actual %b", test_name, rx_busy);
            test_errors++;
        end
    endtask

    // read back every byte of the rows loaded during this test
    task automatic sweep_rows();
        for (int r = 0; r < pixel_height; r++) begin
            if (rows_touched[row_bits'(r)]) begin
                for (int k = 0; k < row_bytes; k++) begin
                    @(negedge clk_in);
                    read_address = addr_width'(expected_address(r, k));
                    @(negedge clk_in);
                    if (read_data !== model_frame[read_address]) begin
                        $display("FAILED %0s row %0d byte %0d expected %02h actual %02h",
                                 test_name, r, k, model_frame[read_address], read_data);
                        test_errors++;
                    end
                end
            end
        end
    endtask

    task automatic report_test();
        tests_run++;
        error_count += test_errors;
        if (test_errors == 0) begin
            $display("PASS %0s", test_name);
        end else begin
            tests_failed++;
            $display("FAIL %0s with %0d mismatches", test_name, test_errors);
        end
        test_errors  = 0;
        rows_touched = '0;
    endtask

    initial begin
        model_display = display_ctrl_reset;
        model_done    = 8'd0;
        model_phase   = 0;
        model_row     = 0;
        model_k       = 0;
        rows_touched  = '0;
        test_errors   = 0;
        tests_run     = 0;
        tests_failed  = 0;
        error_count   = 0;
        test_done     = 1'b0;
        read_address  = '0;
        forever begin
            @(posedge clk_in);
            if (byte_strobe) begin
                apply_byte(byte_value);
                // outputs settle one cycle after the stop-bit strobe
                @(negedge clk_in);
                while (!rx_busy)
                    @(negedge clk_in);
                while (rx_busy)
                    @(negedge clk_in);
                repeat (2) @(negedge clk_in);
                compare_state();
            end else if (test_end) begin
                @(negedge clk_in);
                compare_state();
                sweep_rows();
                report_test();
                @(negedge clk_in);
                test_done = 1'b1;
                @(negedge clk_in);
                test_done = 1'b0;
            end
        end
    end

endmodule

// ==== sim/tb_top.sv ====
module tb_top
    import matrix_pkg::*;
();

    localparam int clk_ticks_per_bit = 8;
    localparam int pixel_width       = 64;
    localparam int pixel_height      = 32;
    localparam int bytes_per_pixel   = 2;
    localparam int clk_period        = 4;
    localparam int row_bytes         = pixel_width * bytes_per_pixel;
    localparam int address_width     = $clog2(pixel_height) + $clog2(row_bytes);
    // colour 8, brightness 16, line 130, repeated L 131, back to back 260
    localparam int total_bytes       = 545;
    // 12 bit times per byte, margin for reset and the read-back sweeps
    localparam int watchdog_cycles   = total_bytes * 12 * clk_ticks_per_bit + 6000;

    logic                     clk_in;
    logic                     reset;
    logic                     serial_in;
    logic                     rx_busy;
    display_ctrl_t            display_ctrl;
    logic [7:0]               commands_done;
    logic [address_width-1:0] read_address;
    logic [7:0]               read_data;
    logic                     byte_strobe;
    data_byte_t               byte_value;
    logic [191:0]             test_name;
    logic                     test_end;
    logic                     test_done;
    int                       tests_run;
    int                       tests_failed;
    int                       error_count;
    integer                   seed;

    matrix_control_top #(
        .clk_ticks_per_bit(clk_ticks_per_bit),
        .pixel_width      (pixel_width),
        .pixel_height     (pixel_height),
        .bytes_per_pixel  (bytes_per_pixel)
    ) matrix_control_top_i (
        .clk_in       (clk_in),
        .reset        (reset),
        .serial_in    (serial_in),
        .rx_busy      (rx_busy),
        .display_ctrl (display_ctrl),
        .commands_done(commands_done),
        .read_address (read_address),
        .read_data    (read_data)
    );

    tb_checker #(
        .pixel_width    (pixel_width),
        .pixel_height   (pixel_height),
        .bytes_per_pixel(bytes_per_pixel)
    ) checker_i (
        .clk_in       (clk_in),
        .byte_strobe  (byte_strobe),
        .byte_value   (byte_value),
        .test_name    (test_name),
        .test_end     (test_end),
        .test_done    (test_done),
        .rx_busy      (rx_busy),
        .display_ctrl (display_ctrl),
        .commands_done(commands_done),
        .read_address (read_address),
        .read_data    (read_data),
        .tests_run    (tests_run),
        .tests_failed (tests_failed),
        .error_count  (error_count)
    );

    initial begin
        clk_in = 1'b0;
        forever #(clk_period / 2) clk_in = ~clk_in;
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("timeout: run still busy after %0d clock cycles", watchdog_cycles);
        $display("sim failed");
        $finish;
    end

    // 8N1 frame on falling edges, then two idle bits
    task automatic send_byte(input data_byte_t b);
        data_byte_t shift_bits;
        shift_bits = b;
        @(negedge clk_in);
        byte_value  = b;
        byte_strobe = 1'b1;
        serial_in   = 1'b0;
        @(negedge clk_in);
        byte_strobe = 1'b0;
        repeat (clk_ticks_per_bit - 1) @(negedge clk_in);
        for (int i = 0; i < 8; i++) begin
            serial_in  = shift_bits[0];
            shift_bits = shift_bits >> 1;
            repeat (clk_ticks_per_bit) @(negedge clk_in);
        end
        serial_in = 1'b1;
        repeat (3 * clk_ticks_per_bit) @(negedge clk_in);
    endtask

    // row byte and one full row, optionally with command codes as pixels
    task automatic send_row_data(input int row, input bit mixed);
        data_byte_t mixed_bytes [$];
        mixed_bytes = '{cmd_red_off, cmd_green_on, cmd_blue_off, cmd_planes_off};
        send_byte(data_byte_t'(row));
        for (int k = 0; k < row_bytes; k++) begin
            if (mixed && k % 16 == 5) begin
                send_byte(mixed_bytes[(k / 16) % 4]);
            end else begin
                send_byte(data_byte_t'($random(seed)));
            end
        end
    endtask

    task automatic finish_test();
        @(negedge clk_in);
        test_end = 1'b1;
        while (!test_done)
            @(posedge clk_in);
        @(negedge clk_in);
        test_end = 1'b0;
    endtask

    initial begin
        data_byte_t colour_seq [$];
        data_byte_t planes [$];
        data_byte_t swap_byte;
        int         pick;
        int         row_a;
        int         row_b;
        seed        = 32'h537;
        reset       = 1'b1;
        serial_in   = 1'b1;
        byte_strobe = 1'b0;
        byte_value  = 8'h00;
        test_end    = 1'b0;
        test_name   = "reset";
        repeat (3) @(posedge clk_in);
        @(negedge clk_in);
        reset = 1'b0;
        finish_test();

        test_name  = "colour";
        colour_seq = '{cmd_red_off, cmd_green_off, cmd_blue_off, "x",
                       cmd_green_on, cmd_blue_on, cmd_red_on, cmd_blue_off};
        foreach (colour_seq[i])
            send_byte(colour_seq[i]);
        finish_test();

        // each plane toggled twice in shuffled order
        test_name = "brightness";
        for (int i = 0; i < 12; i++)
            planes.push_back(data_byte_t'(int'(cmd_plane_1) + i % 6));
        for (int i = 11; i > 0; i--) begin
            pick         = ($random(seed) & 32'h7fffffff) % (i + 1);
            swap_byte    = planes[i];
            planes[i]    = planes[pick];
            planes[pick] = swap_byte;
        end
        foreach (planes[i])
            send_byte(planes[i]);
        // mixed plane state ahead of each all-off and all-on
        send_byte(cmd_plane_1);
        send_byte(cmd_planes_off);
        send_byte(cmd_plane_1);
        send_byte(cmd_planes_on);
        finish_test();

        test_name = "line_random";
        row_a     = ($random(seed) & 32'h7fffffff) % pixel_height;
        send_byte(cmd_line);
        send_row_data(row_a, 1'b0);
        finish_test();

        test_name = "line_repeat_l";
        row_a     = ($random(seed) & 32'h7fffffff) % pixel_height;
        send_byte(cmd_line);
        send_byte(cmd_line);
        send_row_data(row_a, 1'b1);
        finish_test();

        test_name = "line_back_to_back";
        row_a     = ($random(seed) & 32'h7fffffff) % pixel_height;
        row_b     = (row_a + 7) % pixel_height;
        send_byte(cmd_line);
        send_row_data(row_a, 1'b0);
        send_byte(cmd_line);
        send_row_data(row_b, 1'b0);
        finish_test();

        $display("%0d tests run, %0d failed, %0d mismatches",
                 tests_run, tests_failed, error_count);
        if (error_count == 0 && tests_failed == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== list.f ====
source/matrix_pkg.sv
source/uart_rx.sv
source/command_decoder.sv
source/frame_ram.sv
source/matrix_control_top.sv
sim/tb_checker.sv
sim/tb_top.sv

// ==== run_sim.sh ====
#!/bin/bash
# build with Verilator, run, and scan the log for the failure line
cd "$(dirname "$0")" || exit 1
log=sim.log
rm -rf obj_dir "$log"
verilator --binary --timing -f list.f --top-module tb_top -o tb_top_sim > "$log" 2>&1 \
    && ./obj_dir/tb_top_sim >> "$log" 2>&1 \
    || echo "sim failed" >> "$log"
grep -q "sim failed" "$log" && echo "FAIL, see $log" && exit 1 \
    || echo "PASS, see $log"
exit 0
